//--- flist.f
+incdir+.
fetch_pkg.sv
pc_reg.sv
branch_predictor.sv
if_id_reg.sv
fetch_top.sv
tb_fetch_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_fetch_top \
    -f flist.f -o sim_fetch > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_fetch > sim.log 2>&1
cat sim.log

# the log decides the result
grep -q "TEST FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "TEST OK" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

//--- tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module tb_fetch_top
    import fetch_pkg::*;
();

    localparam int               HALF_PERIOD    = 10;
    localparam int               RESET_CYCLES   = 4;
    localparam int               NUM_RANDOM     = 400;
    localparam int               ENABLE_TIMEOUT = 8;
    localparam logic [31:0]      RAND_SEED      = 32'h43d5d193;

    // one table row is one clock of stimulus
    typedef struct packed {
        logic                     stall;
        logic                     bflush;
        logic [`FETCH_ADDR_W-1:0] baddr;
        logic                     eflush;
        logic [`FETCH_ADDR_W-1:0] eaddr;
        logic                     irq;
        logic                     uvalid;
        logic [`FETCH_ADDR_W-1:0] upc;
        logic                     utaken;
        logic [`FETCH_ADDR_W-1:0] utgt;
        logic                     chk_pc;
        logic [`FETCH_ADDR_W-1:0] exp_pc;
    } row_t;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     stall;
    logic                     branch_flush;
    logic [`FETCH_ADDR_W-1:0] branch_actual_addr;
    logic                     exception_flush;
    logic [`FETCH_ADDR_W-1:0] exception_new_pc;
    logic                     is_interrupt;
    logic                     update_valid;
    logic [`FETCH_ADDR_W-1:0] update_pc;
    logic                     update_taken;
    logic [`FETCH_ADDR_W-1:0] update_target;
    logic                     inst_en;
    logic [`FETCH_ADDR_W-1:0] inst_addr;
    logic [`FETCH_ADDR_W-1:0] inst_rdata = '0;
    logic                     id_valid;
    logic [`FETCH_ADDR_W-1:0] id_pc;
    logic [`FETCH_ADDR_W-1:0] id_instr;
    logic                     id_pred_taken;
    logic [`FETCH_ADDR_W-1:0] id_pred_target;
    logic                     id_exception;
    ecode_t                   id_ecode;

    row_t        rows[$];
    logic [31:0] rng;

    // address and enable seen by the memory at the last rising edge
    logic [`FETCH_ADDR_W-1:0] mem_addr_q = '0;
    logic                     mem_en_q   = 1'b0;

    // reference model of fetch pc, slot and decode entry
    logic [31:0] m_pc;
    logic        m_en;
    logic        s_valid;
    logic [31:0] s_pc;
    logic        s_exc;
    ecode_t      s_ecode;
    logic        s_pt;
    logic [31:0] s_ptgt;
    logic        d_valid;
    logic [31:0] d_pc;
    logic        d_exc;
    ecode_t      d_ecode;
    logic        d_pt;
    logic [31:0] d_ptgt;

    // reference btb
    logic [`BP_ENTRIES-1:0] b_valid;
    logic [31:0]            b_tag [`BP_ENTRIES];
    logic [31:0]            b_tgt [`BP_ENTRIES];
    bp_state_t              b_cnt [`BP_ENTRIES];

    always #HALF_PERIOD clk = ~clk;

    fetch_top i_fetch_top (
        .clk                (clk),
        .rst                (rst),
        .stall              (stall),
        .branch_flush       (branch_flush),
        .branch_actual_addr (branch_actual_addr),
        .exception_flush    (exception_flush),
        .exception_new_pc   (exception_new_pc),
        .is_interrupt       (is_interrupt),
        .update_valid       (update_valid),
        .update_pc          (update_pc),
        .update_taken       (update_taken),
        .update_target      (update_target),
        .inst_en            (inst_en),
        .inst_addr          (inst_addr),
        .inst_rdata         (inst_rdata),
        .id_valid           (id_valid),
        .id_pc              (id_pc),
        .id_instr           (id_instr),
        .id_pred_taken      (id_pred_taken),
        .id_pred_target     (id_pred_target),
        .id_exception       (id_exception),
        .id_ecode           (id_ecode)
    );

    //////////////////////////////////////////////////
    // instruction memory model
    //////////////////////////////////////////////////

    // odd multiplier lets every address bit reach the word
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h1357_9bdf;
    endfunction

    // word for the address of the previous rising edge
    // pc is registered, so the falling edge sees what that edge saw
    always @(negedge clk) begin
        if (mem_en_q === 1'b1) begin
            inst_rdata = mem_word(mem_addr_q);
        end
        mem_addr_q = inst_addr;
        mem_en_q   = inst_en;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    task automatic reset_model();
        m_pc    = `FETCH_RESET_PC;
        m_en    = 1'b0;
        s_valid = 1'b0;
        s_exc   = 1'b0;
        s_ecode = ECODE_NONE;
        s_pt    = 1'b0;
        d_valid = 1'b0;
        d_exc   = 1'b0;
        d_ecode = ECODE_NONE;
        d_pt    = 1'b0;
        b_valid = '0;
    endtask

    // state after the next rising edge with this row applied
    task automatic step_model(input row_t r);
        logic [`BP_INDEX_W-1:0] idx;
        logic [`BP_INDEX_W-1:0] uidx;
        logic [31:0]            utag;
        logic                   hit;
        logic                   pred;
        logic [31:0]            tgt;
        logic                   f_exc;
        ecode_t                 f_ecode;
        logic                   stage_flush;

        // lookup sees the table as it was before this edge
        idx  = m_pc[`BP_INDEX_W+1:2];
        hit  = b_valid[idx] && (b_tag[idx] == (m_pc >> (`BP_INDEX_W + 2)));
        pred = hit && (b_cnt[idx] == WEAK_T || b_cnt[idx] == STRONG_T);
        tgt  = b_tgt[idx];

        // interrupt ahead of adef
        f_exc   = r.irq || (m_pc[1:0] != 2'b00);
        f_ecode = r.irq ? ECODE_INT : (m_pc[1:0] != 2'b00) ? ECODE_ADEF : ECODE_NONE;

        // a mispredict under stall is ignored by pc, so by the stage too
        stage_flush = r.eflush || (r.bflush && !r.stall);

        if (stage_flush) begin
            s_valid = 1'b0;
            s_exc   = 1'b0;
            s_ecode = ECODE_NONE;
            s_pt    = 1'b0;
            d_valid = 1'b0;
            d_exc   = 1'b0;
            d_ecode = ECODE_NONE;
            d_pt    = 1'b0;
        end else if (!r.stall) begin
            d_valid = s_valid;
            d_pc    = s_pc;
            d_exc   = s_exc;
            d_ecode = s_ecode;
            d_pt    = s_pt;
            d_ptgt  = s_ptgt;
            s_valid = m_en;
            s_pc    = m_pc;
            s_exc   = m_en && f_exc;
            s_ecode = m_en ? f_ecode : ECODE_NONE;
            s_pt    = m_en && pred;
            s_ptgt  = tgt;
        end

        // next pc priority
        if (r.eflush) begin
            m_pc = r.eaddr;
        end else if (!r.stall) begin
            if (r.bflush) begin
                m_pc = r.baddr;
            end else if (pred) begin
                m_pc = tgt;
            end else begin
                m_pc = m_pc + 32'd4;
            end
        end
        m_en = 1'b1;

        // resolve update becomes visible at the next lookup
        if (r.uvalid) begin
            uidx = r.upc[`BP_INDEX_W+1:2];
            utag = r.upc >> (`BP_INDEX_W + 2);
            if (b_valid[uidx] && (b_tag[uidx] == utag)) begin
                if (r.utaken) begin
                    if (b_cnt[uidx] != STRONG_T) begin
                        b_cnt[uidx] = bp_state_t'(b_cnt[uidx] + 2'd1);
                    end
                    b_tgt[uidx] = r.utgt;
                end else if (b_cnt[uidx] != STRONG_NT) begin
                    b_cnt[uidx] = bp_state_t'(b_cnt[uidx] - 2'd1);
                end
            end else begin
                // new branch starts weak in its resolved direction
                b_valid[uidx] = 1'b1;
                b_tag[uidx]   = utag;
                b_tgt[uidx]   = r.utgt;
                b_cnt[uidx]   = r.utaken ? WEAK_T : WEAK_NT;
            end
        end
    endtask

    task automatic check_outputs();
        logic [31:0] exp_instr;
        check_value("inst_en", 32'(inst_en), 32'(m_en));
        check_value("inst_addr", inst_addr, m_pc);
        check_value("id_valid", 32'(id_valid), 32'(d_valid));
        check_value("id_exception", 32'(id_exception), 32'(d_exc));
        check_value("id_ecode", 32'(id_ecode), 32'(d_ecode));
        check_value("id_pred_taken", 32'(id_pred_taken), 32'(d_pt));
        // payload only means something on a valid entry
        if (d_valid) begin
            exp_instr = d_exc ? '0 : mem_word(d_pc);
            check_value("id_pc", id_pc, d_pc);
            check_value("id_instr", id_instr, exp_instr);
            if (d_pt) begin
                check_value("id_pred_target", id_pred_target, d_ptgt);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////

    task automatic add_row(input logic st, input logic bf, input logic [31:0] ba,
                           input logic ef, input logic [31:0] ea, input logic irq,
                           input logic [31:0] exp_pc);
        row_t r;
        r        = '0;
        r.stall  = st;
        r.bflush = bf;
        r.baddr  = ba;
        r.eflush = ef;
        r.eaddr  = ea;
        r.irq    = irq;
        r.chk_pc = 1'b1;
        r.exp_pc = exp_pc;
        rows.push_back(r);
    endtask

    task automatic add_idle(input logic [31:0] exp_pc);
        add_row(1'b0, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, exp_pc);
    endtask

    task automatic add_update(input logic [31:0] upc, input logic taken,
                              input logic [31:0] tgt, input logic [31:0] exp_pc);
        row_t r;
        r        = '0;
        r.uvalid = 1'b1;
        r.upc    = upc;
        r.utaken = taken;
        r.utgt   = tgt;
        r.chk_pc = 1'b1;
        r.exp_pc = exp_pc;
        rows.push_back(r);
    endtask

    // exp_pc is inst_addr after the row's edge
    task automatic build_directed_rows();
        // sequential from 0x100
        add_idle(32'h104);
        add_idle(32'h108);
        add_idle(32'h10c);
        // stall hold, then exception under stall
        add_row(1'b1, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 32'h10c);
        add_row(1'b1, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 32'h10c);
        add_row(1'b1, 1'b0, 32'h0, 1'b1, 32'h200, 1'b0, 32'h200);
        add_idle(32'h204);
        add_idle(32'h208);
        // mispredict under stall loses to the hold
        add_row(1'b1, 1'b1, 32'h280, 1'b0, 32'h0, 1'b0, 32'h208);
        add_row(1'b0, 1'b1, 32'h300, 1'b0, 32'h0, 1'b0, 32'h300);
        add_idle(32'h304);
        add_idle(32'h308);
        // exception address wins over a mispredict
        add_row(1'b0, 1'b1, 32'h400, 1'b1, 32'h500, 1'b0, 32'h500);
        add_idle(32'h504);
        // taken branch at 0x510 to 0x600
        add_update(32'h510, 1'b1, 32'h600, 32'h508);
        add_idle(32'h50c);
        add_idle(32'h510);
        add_idle(32'h600);
        add_idle(32'h604);
        add_idle(32'h608);
        // two not-taken updates bring it back to strong not-taken
        add_update(32'h510, 1'b0, 32'h600, 32'h60c);
        add_update(32'h510, 1'b0, 32'h600, 32'h610);
        add_row(1'b0, 1'b1, 32'h50c, 1'b0, 32'h0, 1'b0, 32'h50c);
        add_idle(32'h510);
        add_idle(32'h514);
        add_idle(32'h518);
        // misaligned exception target gives adef
        add_row(1'b0, 1'b0, 32'h0, 1'b1, 32'h702, 1'b0, 32'h702);
        add_idle(32'h706);
        add_idle(32'h70a);
        // interrupt on a misaligned pc reports int
        add_row(1'b0, 1'b0, 32'h0, 1'b0, 32'h0, 1'b1, 32'h70e);
        add_idle(32'h712);
        add_row(1'b0, 1'b0, 32'h0, 1'b1, 32'h800, 1'b0, 32'h800);
        add_row(1'b0, 1'b0, 32'h0, 1'b0, 32'h0, 1'b1, 32'h804);
        add_idle(32'h808);
        add_idle(32'h80c);
        add_idle(32'h810);
    endtask

    // random rows checked against the model only
    task automatic build_random_rows();
        row_t        r;
        logic [31:0] ctl;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            ctl      = next_rand();
            r        = '0;
            r.stall  = (ctl[2:0] == 3'd0);
            r.bflush = (ctl[6:3] == 4'd0);
            r.eflush = (ctl[11:7] == 5'd0);
            r.irq    = (ctl[16:12] == 5'd0);
            r.uvalid = (ctl[18:17] == 2'd0);
            r.utaken = ctl[19];
            // small window so updates and lookups collide
            r.baddr  = 32'h0000_1000 | (next_rand() & 32'h0000_00fc);
            r.eaddr  = 32'h0000_1000 |
                       (next_rand() & ((ctl[21:20] == 2'd0) ? 32'h0000_00ff : 32'h0000_00fc));
            r.upc    = 32'h0000_1000 | (next_rand() & 32'h0000_00fc);
            r.utgt   = 32'h0000_1000 | (next_rand() & 32'h0000_00fc);
            rows.push_back(r);
        end
    endtask

    task automatic apply_row(input row_t r);
        stall              = r.stall;
        branch_flush       = r.bflush;
        branch_actual_addr = r.baddr;
        exception_flush    = r.eflush;
        exception_new_pc   = r.eaddr;
        is_interrupt       = r.irq;
        update_valid       = r.uvalid;
        update_pc          = r.upc;
        update_taken       = r.utaken;
        update_target      = r.utgt;
        step_model(r);
    endtask

    task automatic wait_fetch_enable();
        row_t idle;
        int   cycles;
        idle   = '0;
        cycles = 0;
        while (inst_en !== 1'b1 && cycles < ENABLE_TIMEOUT) begin
            apply_row(idle);
            @(negedge clk);
            check_outputs();
            cycles++;
        end
        if (inst_en !== 1'b1) begin
            $display("timeout: inst_en still low %0d cycles after reset", cycles);
            $display("TEST FAILED");
            $fatal(1, "fetch never enabled");
        end
        // enable register follows reset by one edge
        check_value("cycles to inst_en", 32'(cycles), 32'd1);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        rst                = 1'b1;
        stall              = 1'b0;
        branch_flush       = 1'b0;
        branch_actual_addr = '0;
        exception_flush    = 1'b0;
        exception_new_pc   = '0;
        is_interrupt       = 1'b0;
        update_valid       = 1'b0;
        update_pc          = '0;
        update_taken       = 1'b0;
        update_target      = '0;
        rng                = RAND_SEED;

        build_directed_rows();
        build_random_rows();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        // still in reset here
        check_value("reset pc", inst_addr, `FETCH_RESET_PC);
        check_value("reset inst_en", 32'(inst_en), 32'd0);
        check_value("reset id_valid", 32'(id_valid), 32'd0);
        check_value("reset id_exception", 32'(id_exception), 32'd0);

        rst = 1'b0;
        reset_model();
        wait_fetch_enable();

        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
            @(negedge clk);
            check_outputs();
            if (rows[i].chk_pc) begin
                check_value("table pc", inst_addr, rows[i].exp_pc);
            end
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_top
    import fetch_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst,

    // pipeline control
    input  wire logic                     stall,
    input  wire logic                     branch_flush,
    input  wire logic [`FETCH_ADDR_W-1:0] branch_actual_addr,
    input  wire logic                     exception_flush,
    input  wire logic [`FETCH_ADDR_W-1:0] exception_new_pc,
    input  wire logic                     is_interrupt,

    // branch resolve
    input  wire logic                     update_valid,
    input  wire logic [`FETCH_ADDR_W-1:0] update_pc,
    input  wire logic                     update_taken,
    input  wire logic [`FETCH_ADDR_W-1:0] update_target,

    // instruction memory, synchronous read
    output logic                          inst_en,
    output logic [`FETCH_ADDR_W-1:0]      inst_addr,
    input  wire logic [`FETCH_ADDR_W-1:0] inst_rdata,

    // decode stage
    output logic                          id_valid,
    output logic [`FETCH_ADDR_W-1:0]      id_pc,
    output logic [`FETCH_ADDR_W-1:0]      id_instr,
    output logic                          id_pred_taken,
    output logic [`FETCH_ADDR_W-1:0]      id_pred_target,
    output logic                          id_exception,
    output ecode_t                        id_ecode
);

    logic [`FETCH_ADDR_W-1:0] pc;
    logic                     bp_hit;
    logic                     bp_taken;
    logic [`FETCH_ADDR_W-1:0] bp_target;
    logic                     fetch_exception;
    ecode_t                   fetch_ecode;
    logic                     stage_flush;
    logic                     fetch_pred_taken;

    //////////////////////////////////////////////////
    // glue
    //////////////////////////////////////////////////

    assign inst_addr = pc;

    // pc ignores a mispredict while stalled, so the stage must too
    assign stage_flush = exception_flush | (branch_flush & ~stall);

    // counter bit means nothing without a tag hit
    assign fetch_pred_taken = bp_taken & bp_hit;

    pc_reg i_pc_reg (
        .clk                (clk),
        .rst                (rst),
        .stall              (stall),
        .branch_flush       (branch_flush),
        .branch_actual_addr (branch_actual_addr),
        .exception_flush    (exception_flush),
        .exception_new_pc   (exception_new_pc),
        .is_interrupt       (is_interrupt),
        .bp_hit             (bp_hit),
        .bp_taken           (bp_taken),
        .bp_target          (bp_target),
        .pc                 (pc),
        .inst_en            (inst_en),
        .fetch_exception    (fetch_exception),
        .fetch_ecode        (fetch_ecode)
    );

    // looks up the pc being issued this cycle
    branch_predictor i_branch_predictor (
        .clk           (clk),
        .rst           (rst),
        .lookup_pc     (pc),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target),
        .bp_hit        (bp_hit),
        .bp_taken      (bp_taken),
        .bp_target     (bp_target)
    );

    if_id_reg i_if_id_reg (
        .clk               (clk),
        .rst               (rst),
        .stall             (stall),
        .flush             (stage_flush),
        .fetch_valid       (inst_en),
        .fetch_pc          (pc),
        .fetch_exception   (fetch_exception),
        .fetch_ecode       (fetch_ecode),
        .fetch_pred_taken  (fetch_pred_taken),
        .fetch_pred_target (bp_target),
        .inst_rdata        (inst_rdata),
        .id_valid          (id_valid),
        .id_pc             (id_pc),
        .id_instr          (id_instr),
        .id_pred_taken     (id_pred_taken),
        .id_pred_target    (id_pred_target),
        .id_exception      (id_exception),
        .id_ecode          (id_ecode)
    );

endmodule

`default_nettype wire

//--- if_id_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module if_id_reg
    import fetch_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     stall,
    input  wire logic                     flush,

    // fetch side, sampled with the memory address
    input  wire logic                     fetch_valid,
    input  wire logic [`FETCH_ADDR_W-1:0] fetch_pc,
    input  wire logic                     fetch_exception,
    input  wire ecode_t                   fetch_ecode,
    input  wire logic                     fetch_pred_taken,
    input  wire logic [`FETCH_ADDR_W-1:0] fetch_pred_target,
    input  wire logic [`FETCH_ADDR_W-1:0] inst_rdata,

    // decode side
    output logic                          id_valid,
    output logic [`FETCH_ADDR_W-1:0]      id_pc,
    output logic [`FETCH_ADDR_W-1:0]      id_instr,
    output logic                          id_pred_taken,
    output logic [`FETCH_ADDR_W-1:0]      id_pred_target,
    output logic                          id_exception,
    output ecode_t                        id_ecode
);

    // slot holds the fetch whose word is still in memory
    logic                     slot_valid;
    logic [`FETCH_ADDR_W-1:0] slot_pc;
    logic                     slot_exception;
    ecode_t                   slot_ecode;
    logic                     slot_pred_taken;
    logic [`FETCH_ADDR_W-1:0] slot_pred_target;

    // inst_rdata belongs to the slot this cycle
    logic                     word_pending;
    logic [`FETCH_ADDR_W-1:0] held_instr;
    logic [`FETCH_ADDR_W-1:0] slot_instr;

    //////////////////////////////////////////////////
    // returning word
    //////////////////////////////////////////////////

    // a stalled edge re-reads pc, so save the slot word first
    always_ff @(posedge clk) begin
        if (word_pending) begin
            held_instr <= inst_rdata;
        end
    end

    assign slot_instr = word_pending ? inst_rdata : held_instr;

    //////////////////////////////////////////////////
    // control fields
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            word_pending    <= 1'b0;
            slot_valid      <= 1'b0;
            slot_exception  <= 1'b0;
            slot_ecode      <= ECODE_NONE;
            slot_pred_taken <= 1'b0;
            id_valid        <= 1'b0;
            id_exception    <= 1'b0;
            id_ecode        <= ECODE_NONE;
            id_pred_taken   <= 1'b0;
        end else begin
            // memory read matches the slot only on an unstalled edge
            word_pending <= !stall;
            if (flush) begin
                // bubble in both places, wins over stall
                slot_valid      <= 1'b0;
                slot_exception  <= 1'b0;
                slot_ecode      <= ECODE_NONE;
                slot_pred_taken <= 1'b0;
                id_valid        <= 1'b0;
                id_exception    <= 1'b0;
                id_ecode        <= ECODE_NONE;
                id_pred_taken   <= 1'b0;
            end else if (!stall) begin
                slot_valid      <= fetch_valid;
                slot_exception  <= fetch_valid && fetch_exception;
                slot_ecode      <= fetch_valid ? fetch_ecode : ECODE_NONE;
                slot_pred_taken <= fetch_valid && fetch_pred_taken;
                id_valid        <= slot_valid;
                id_exception    <= slot_exception;
                id_ecode        <= slot_ecode;
                id_pred_taken   <= slot_pred_taken;
            end
        end
    end

    //////////////////////////////////////////////////
    // payload fields
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!stall) begin
            slot_pc          <= fetch_pc;
            slot_pred_target <= fetch_pred_target;
            id_pc            <= slot_pc;
            id_pred_target   <= slot_pred_target;
            // faulting fetch goes to decode as a zero word
            id_instr         <= slot_exception ? '0 : slot_instr;
        end
    end

endmodule

`default_nettype wire

//--- branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module branch_predictor
    import fetch_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst,

    // lookup side, combinational
    input  wire logic [`FETCH_ADDR_W-1:0] lookup_pc,

    // resolve side, one-cycle pulse
    input  wire logic                     update_valid,
    input  wire logic [`FETCH_ADDR_W-1:0] update_pc,
    input  wire logic                     update_taken,
    input  wire logic [`FETCH_ADDR_W-1:0] update_target,

    output logic                          bp_hit,
    output logic                          bp_taken,
    output logic [`FETCH_ADDR_W-1:0]      bp_target
);

    // tag sits above index and byte offset
    localparam int TAG_LSB = `BP_INDEX_W + 2;
    localparam int TAG_W   = `FETCH_ADDR_W - TAG_LSB;

    //////////////////////////////////////////////////
    // btb storage
    //////////////////////////////////////////////////

    logic [`BP_ENTRIES-1:0]   entry_valid;
    logic [TAG_W-1:0]         entry_tag    [`BP_ENTRIES];
    logic [`FETCH_ADDR_W-1:0] entry_target [`BP_ENTRIES];
    bp_state_t                entry_cnt    [`BP_ENTRIES];

    logic [`BP_INDEX_W-1:0]   lookup_idx;
    logic [TAG_W-1:0]         lookup_tag;
    logic [`BP_INDEX_W-1:0]   update_idx;
    logic [TAG_W-1:0]         update_tag;
    logic                     update_match;
    bp_state_t                cnt_next;

    // saturating two-bit step
    function automatic bp_state_t cnt_step(input bp_state_t cur, input logic taken);
        bp_state_t nxt;
        nxt = cur;
        case (cur)
            STRONG_NT: nxt = taken ? WEAK_NT : STRONG_NT;
            WEAK_NT:   nxt = taken ? WEAK_T : STRONG_NT;
            WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
            STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;
            default:   nxt = WEAK_NT;
        endcase
        return nxt;
    endfunction

    //////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////

    // pc[5:2] picks the entry
    assign lookup_idx = lookup_pc[TAG_LSB-1:2];
    assign lookup_tag = lookup_pc[`FETCH_ADDR_W-1:TAG_LSB];

    assign bp_hit    = entry_valid[lookup_idx] && (entry_tag[lookup_idx] == lookup_tag);
    // counter msb, qualified by hit downstream
    assign bp_taken  = entry_cnt[lookup_idx][1];
    assign bp_target = entry_target[lookup_idx];

    //////////////////////////////////////////////////
    // update
    //////////////////////////////////////////////////

    assign update_idx = update_pc[TAG_LSB-1:2];
    assign update_tag = update_pc[`FETCH_ADDR_W-1:TAG_LSB];

    // same branch already resident
    assign update_match = entry_valid[update_idx] && (entry_tag[update_idx] == update_tag);

    always_comb begin
        if (update_match) begin
            cnt_next = cnt_step(entry_cnt[update_idx], update_taken);
        end else if (update_taken) begin
            // fresh entry starts weak in the resolved direction
            cnt_next = WEAK_T;
        end else begin
            cnt_next = WEAK_NT;
        end
    end

    // valid bits are the only state cleared by reset
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else if (update_valid) begin
            entry_valid[update_idx] <= 1'b1;
        end
    end

    // tag, counter and target written on the update edge
    // lookups see them from the next cycle
    always_ff @(posedge clk) begin
        if (update_valid) begin
            entry_tag[update_idx] <= update_tag;
            entry_cnt[update_idx] <= cnt_next;
            // a not-taken update keeps a known target
            if (!update_match || update_taken) begin
                entry_target[update_idx] <= update_target;
            end
        end
    end

endmodule

`default_nettype wire

//--- pc_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module pc_reg
    import fetch_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst,

    // pipeline control levels
    input  wire logic                     stall,
    input  wire logic                     branch_flush,
    input  wire logic [`FETCH_ADDR_W-1:0] branch_actual_addr,
    input  wire logic                     exception_flush,
    input  wire logic [`FETCH_ADDR_W-1:0] exception_new_pc,
    input  wire logic                     is_interrupt,

    // predictor result for the current pc
    input  wire logic                     bp_hit,
    input  wire logic                     bp_taken,
    input  wire logic [`FETCH_ADDR_W-1:0] bp_target,

    // fetch address and tags
    output logic [`FETCH_ADDR_W-1:0]      pc,
    output logic                          inst_en,
    output logic                          fetch_exception,
    output ecode_t                        fetch_ecode
);

    // sequential increment
    localparam logic [`FETCH_ADDR_W-1:0] PC_STEP = 4;

    logic                     pc_misaligned;
    logic                     pred_redirect;
    logic [`FETCH_ADDR_W-1:0] pc_next;

    //////////////////////////////////////////////////
    // instruction enable
    //////////////////////////////////////////////////

    // low through reset, high from the first edge after
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_en <= 1'b0;
        end else begin
            inst_en <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // next pc select
    //////////////////////////////////////////////////

    // only a hit may follow the counter
    assign pred_redirect = bp_hit && bp_taken;

    always_comb begin
        // exception redirect beats the stall hold
        if (exception_flush) begin
            pc_next = exception_new_pc;
        end else if (stall) begin
            pc_next = pc;
        end else if (branch_flush) begin
            // mispredict from execute
            pc_next = branch_actual_addr;
        end else if (pred_redirect) begin
            pc_next = bp_target;
        end else begin
            pc_next = pc + PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `FETCH_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    //////////////////////////////////////////////////
    // fetch exception tags
    //////////////////////////////////////////////////

    // word fetch needs pc[1:0] == 0
    assign pc_misaligned = (pc[1:0] != 2'b00);

    always_comb begin
        fetch_exception = is_interrupt || pc_misaligned;
        // interrupt reported ahead of adef
        if (is_interrupt) begin
            fetch_ecode = ECODE_INT;
        end else if (pc_misaligned) begin
            fetch_ecode = ECODE_ADEF;
        end else begin
            fetch_ecode = ECODE_NONE;
        end
    end

endmodule

`default_nettype wire

//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    //////////////////////////////////////////////////
    // fetch exception codes
    //////////////////////////////////////////////////

    // loongarch estat ecode values for int and adef
    // none uses a reserved code so it never aliases int
    typedef enum logic [5:0] {
        ECODE_INT  = 6'h00,
        ECODE_ADEF = 6'h08,
        ECODE_NONE = 6'h3f
    } ecode_t;

    //////////////////////////////////////////////////
    // two-bit branch counter
    //////////////////////////////////////////////////

    // msb gives the taken prediction
    // saturates at both ends
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } bp_state_t;

endpackage

`default_nettype wire

//--- fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

//////////////////////////////////////////////////
// fetch front end sizing
//////////////////////////////////////////////////

// pc and instruction word width
`define FETCH_ADDR_W 32

// first pc after reset
// the first sequential step lands on 0x100
`define FETCH_RESET_PC 32'h0000_00fc

//////////////////////////////////////////////////
// branch predictor geometry
//////////////////////////////////////////////////

// direct-mapped btb entries
`define BP_ENTRIES 16

// index bits, taken from pc[5:2]
// keep 2**BP_INDEX_W equal to BP_ENTRIES
`define BP_INDEX_W 4

// tag is everything above the index
// pc[1:0] never takes part in the lookup

`endif
